//--- design/scalar_pkg.sv
//////////////////////////////////////////////////
// Shared definitions for the scalar pipeline
//  data, register index and opcode types
//  instruction, issue and write-back structs
//  APB request and response structs, address map
//  opcode class decode helpers
//////////////////////////////////////////////////

package scalar_pkg;

	typedef logic [31:0] data_t;
	typedef logic [3:0] reg_idx_t;

	typedef enum logic [3:0] {
		NOP  = 4'h0,
		LDI  = 4'h1,
		ADD  = 4'h2,
		SUB  = 4'h3,
		AND  = 4'h4,
		OR   = 4'h5,
		XOR  = 4'h6,
		SHL  = 4'h7,
		HALT = 4'h8
	} opcode_t;

	// Instruction word, imm in the low half
	typedef struct packed {opcode_t opcode; reg_idx_t dst; reg_idx_t src1; reg_idx_t src2; logic [15:0] imm;} instr_t;

	typedef struct packed {logic valid; opcode_t opcode; reg_idx_t dst; data_t a; data_t b; logic [15:0] imm;} exec_req_t;

	typedef struct packed {logic valid; reg_idx_t dst; data_t data;} wb_t;

	typedef struct packed {logic psel; logic penable; logic pwrite; logic [11:0] paddr; data_t pwdata;} apb_req_t;

	typedef struct packed {logic pready; data_t prdata; logic pslverr;} apb_rsp_t;

	// Host address map
	localparam logic [11:0] IMEM_BASE   = 12'h000;
	localparam logic [11:0] CTRL_ADDR   = 12'h100;
	localparam logic [11:0] STATUS_ADDR = 12'h104;

	// Ops that write a destination register
	function automatic logic op_writes(opcode_t op);
		return op inside {LDI, ADD, SUB, AND, OR, XOR, SHL};
	endfunction

	// Ops that read both source registers
	function automatic logic op_reads(opcode_t op);
		return op inside {ADD, SUB, AND, OR, XOR, SHL};
	endfunction

endpackage

//--- design/host_apb_if.sv
//////////////////////////////////////////////////
// APB slave of the scalar pipeline
//  instruction memory writes, start control
//  running/halted flags and retired counter
//  status readback and slave error decode
//////////////////////////////////////////////////
`timescale 1ns/10ps

module host_apb_if import scalar_pkg::*; #(
	parameter int IMEM_DEPTH = 64
) (
	input  logic                          clock,
	input  logic                          reset,
	input  apb_req_t                      apb_req,
	output apb_rsp_t                      apb_rsp,
	output logic                          imem_we,
	output logic [$clog2(IMEM_DEPTH)-1:0] imem_addr,
	output instr_t                        imem_data,
	output logic                          start,
	input  logic                          retire_valid,
	input  logic                          halt
);
	localparam int AW = $clog2(IMEM_DEPTH);

	logic        access;
	logic [11:0] imem_off;
	logic        is_imem;
	logic        is_ctrl;
	logic        is_status;
	logic        slv_err;
	data_t       rdata;
	logic        running;
	logic        halted;
	logic [7:0]  retired;

	// Address decode, access phase only
	assign access    = apb_req.psel && apb_req.penable;
	assign imem_off  = apb_req.paddr - IMEM_BASE;
	assign is_imem   = imem_off < 12'(IMEM_DEPTH * 4);
	assign is_ctrl   = apb_req.paddr == CTRL_ADDR;
	assign is_status = apb_req.paddr == STATUS_ADDR;

	// Program store is locked while running
	assign imem_we   = access && apb_req.pwrite && is_imem && !running;
	assign imem_addr = imem_off[AW+1:2];
	assign imem_data = instr_t'(apb_req.pwdata);
	assign start     = access && apb_req.pwrite && is_ctrl && apb_req.pwdata[0] && !running;

	assign slv_err = access && (!(is_imem || is_ctrl || is_status) ||
		(apb_req.pwrite && is_imem && running));

	always_comb begin
		rdata = '0;
		if (access && !apb_req.pwrite) begin
			if (is_status)
				rdata = {16'h0, retired, 6'h0, halted, running};
			else if (is_ctrl)
				rdata[0] = running;
		end
	end

	assign apb_rsp = '{pready: 1'b1, prdata: rdata, pslverr: slv_err};

	//////////////////////////////////////////////////
	// Run state and retire counter
	always_ff @(posedge clock) begin
		if (reset) begin
			running <= 1'b0;
			halted  <= 1'b0;
			retired <= '0;
		end else if (start) begin
			running <= 1'b1;
			halted  <= 1'b0;
			retired <= '0;
		end else begin
			if (halt) begin
				running <= 1'b0;
				halted  <= 1'b1;
			end
			if (retire_valid)
				retired <= retired + 8'd1;
		end
	end

	// Write-back and HALT only come out of execute while a program runs
	assert property (@(posedge clock) disable iff (reset)
		imem_we |-> !retire_valid && !halt);

endmodule

//--- design/fetch_unit.sv
//////////////////////////////////////////////////
// Instruction fetch
//  instruction memory with registered read
//  program counter and fetch register
//  stall hold and halt flush
//////////////////////////////////////////////////
`timescale 1ns/10ps

module fetch_unit import scalar_pkg::*; #(
	parameter int IMEM_DEPTH = 64
) (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          imem_we,
	input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr,
	input  instr_t                        imem_data,
	input  logic                          start,
	input  logic                          halt,
	input  logic                          stall,
	output instr_t                        instr,
	output logic                          instr_valid
);
	localparam int AW = $clog2(IMEM_DEPTH);

	instr_t          imem [IMEM_DEPTH];
	logic [AW-1:0]   pc;
	logic            active;

	// Host write port
	always_ff @(posedge clock) begin
		if (imem_we)
			imem[imem_addr] <= imem_data;
	end

	// Fetch register, held while issue stalls
	always_ff @(posedge clock) begin
		if (!stall)
			instr <= imem[pc];
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			active      <= 1'b0;
			instr_valid <= 1'b0;
			pc          <= '0;
		end else if (halt) begin
			// Drop whatever was fetched behind the HALT
			active      <= 1'b0;
			instr_valid <= 1'b0;
		end else if (start) begin
			active      <= 1'b1;
			instr_valid <= 1'b0;
			pc          <= '0;
		end else if (!stall) begin
			instr_valid <= active;
			if (active)
				pc <= pc + 1'b1;
		end
	end

endmodule

//--- design/reg_bank.sv
//////////////////////////////////////////////////
// One register file bank
//  half of the registers, picked by index bit 0
//  two asynchronous read ports
//  one synchronous write port from write-back
//////////////////////////////////////////////////
`timescale 1ns/10ps

module reg_bank import scalar_pkg::*; #(
	parameter int NUM_REGS = 16,
	parameter bit BANK_ODD = 1'b0
) (
	input  logic     clock,
	input  logic     reset,
	input  reg_idx_t rd_idx_a,
	input  reg_idx_t rd_idx_b,
	output data_t    rd_data_a,
	output data_t    rd_data_b,
	input  wb_t      wb
);
	localparam int DEPTH = NUM_REGS / 2;
	localparam int IW    = $clog2(NUM_REGS);

	data_t regs [DEPTH];
	logic  wr_en;

	// Bit 0 only chooses the bank
	assign rd_data_a = regs[rd_idx_a[IW-1:1]];
	assign rd_data_b = regs[rd_idx_b[IW-1:1]];

	assign wr_en = wb.valid && (wb.dst[0] == BANK_ODD);

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wb.dst[IW-1:1]] <= wb.data;
		end
	end

endmodule

//--- design/issue_unit.sv
//////////////////////////////////////////////////
// Decode and issue
//  scoreboard of pending destinations
//  RAW and WAW hazard stall
//  operand select from the two banks
//  issue register toward execute
//////////////////////////////////////////////////
`timescale 1ns/10ps

module issue_unit import scalar_pkg::*; #(
	parameter int NUM_REGS = 16
) (
	input  logic      clock,
	input  logic      reset,
	input  instr_t    instr,
	input  logic      instr_valid,
	output logic      stall,
	output reg_idx_t  rd_idx_a,
	output reg_idx_t  rd_idx_b,
	input  data_t     even_a,
	input  data_t     even_b,
	input  data_t     odd_a,
	input  data_t     odd_b,
	input  wb_t       wb,
	output exec_req_t issue
);
	logic [NUM_REGS-1:0] pending;
	logic                src_busy;
	logic                dst_busy;
	logic                halt_busy;
	logic                fire;

	assign rd_idx_a = instr.src1;
	assign rd_idx_b = instr.src2;

	assign src_busy  = op_reads(instr.opcode) && (pending[instr.src1] || pending[instr.src2]);
	assign dst_busy  = op_writes(instr.opcode) && pending[instr.dst];
	// Nothing issues behind a HALT in execute
	assign halt_busy = issue.valid && (issue.opcode == HALT);

	assign stall = instr_valid && (src_busy || dst_busy || halt_busy);
	assign fire  = instr_valid && !stall;

	//////////////////////////////////////////////////
	// Scoreboard
	always_ff @(posedge clock) begin
		if (reset) begin
			pending <= '0;
		end else begin
			if (wb.valid)
				pending[wb.dst] <= 1'b0;
			if (fire && op_writes(instr.opcode))
				pending[instr.dst] <= 1'b1;
		end
	end

	// Issue register
	always_ff @(posedge clock) begin
		if (reset) begin
			issue.valid <= 1'b0;
		end else begin
			issue.valid <= fire;
			if (fire) begin
				issue.opcode <= instr.opcode;
				issue.dst    <= instr.dst;
				issue.a      <= instr.src1[0] ? odd_a : even_a;
				issue.b      <= instr.src2[0] ? odd_b : even_b;
				issue.imm    <= instr.imm;
			end
		end
	end

	// A source being written back this cycle is still pending
	assert property (@(posedge clock) disable iff (reset)
		fire && op_reads(instr.opcode) |->
		!(wb.valid && (wb.dst == instr.src1 || wb.dst == instr.src2)));

endmodule

//--- design/exec_unit.sv
//////////////////////////////////////////////////
// Execute stage
//  single cycle ALU
//  write-back register
//  HALT detect and termination pulse
//////////////////////////////////////////////////
`timescale 1ns/10ps

module exec_unit import scalar_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  exec_req_t issue,
	output wb_t       wb,
	output logic      halt,
	output logic      term
);
	data_t result;

	// ALU
	always_comb begin
		case (issue.opcode)
			LDI:     result = {16'h0, issue.imm};
			ADD:     result = issue.a + issue.b;
			SUB:     result = issue.a - issue.b;
			AND:     result = issue.a & issue.b;
			OR:      result = issue.a | issue.b;
			XOR:     result = issue.a ^ issue.b;
			SHL:     result = issue.a << issue.b[4:0];
			default: result = '0;
		endcase
	end

	// Seen while HALT sits in the issue register
	assign halt = issue.valid && (issue.opcode == HALT);

	//////////////////////////////////////////////////
	// Write-back beat, one cycle after issue
	always_ff @(posedge clock) begin
		if (reset) begin
			wb.valid <= 1'b0;
			term     <= 1'b0;
		end else begin
			// NOP and HALT leave no beat
			wb.valid <= issue.valid && op_writes(issue.opcode);
			term     <= halt;
			if (issue.valid) begin
				wb.dst  <= issue.dst;
				wb.data <= result;
			end
		end
	end

	// Issue stays blocked after HALT, so the pipe drains quietly
	assert property (@(posedge clock) disable iff (reset)
		term |-> !wb.valid ##1 !wb.valid);

endmodule

//--- design/scalar_core.sv
//////////////////////////////////////////////////
// Scalar pipeline top level
//  APB host port, fetch, issue, execute
//  even and odd register banks
//////////////////////////////////////////////////
`timescale 1ns/10ps

module scalar_core import scalar_pkg::*; #(
	parameter int IMEM_DEPTH = 64,
	parameter int NUM_REGS   = 16
) (
	input  logic     clock,
	input  logic     reset,
	input  apb_req_t apb_req,
	output apb_rsp_t apb_rsp,
	output wb_t      retire,
	output logic     term
);
	logic                          imem_we;
	logic [$clog2(IMEM_DEPTH)-1:0] imem_addr;
	instr_t                        imem_data;
	logic                          start;
	logic                          halt;
	logic                          stall;
	instr_t                        instr;
	logic                          instr_valid;
	reg_idx_t                      rd_idx_a;
	reg_idx_t                      rd_idx_b;
	data_t                         even_a;
	data_t                         even_b;
	data_t                         odd_a;
	data_t                         odd_b;
	exec_req_t                     issue;

	host_apb_if #(.IMEM_DEPTH(IMEM_DEPTH)) i_host_apb_if (
		.clock       (clock),
		.reset       (reset),
		.apb_req     (apb_req),
		.apb_rsp     (apb_rsp),
		.imem_we     (imem_we),
		.imem_addr   (imem_addr),
		.imem_data   (imem_data),
		.start       (start),
		.retire_valid(retire.valid),
		.halt        (halt)
	);

	fetch_unit #(.IMEM_DEPTH(IMEM_DEPTH)) i_fetch_unit (
		.clock      (clock),
		.reset      (reset),
		.imem_we    (imem_we),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.start      (start),
		.halt       (halt),
		.stall      (stall),
		.instr      (instr),
		.instr_valid(instr_valid)
	);

	issue_unit #(.NUM_REGS(NUM_REGS)) i_issue_unit (
		.clock      (clock),
		.reset      (reset),
		.instr      (instr),
		.instr_valid(instr_valid),
		.stall      (stall),
		.rd_idx_a   (rd_idx_a),
		.rd_idx_b   (rd_idx_b),
		.even_a     (even_a),
		.even_b     (even_b),
		.odd_a      (odd_a),
		.odd_b      (odd_b),
		.wb         (retire),
		.issue      (issue)
	);

	// Both banks see the same read indexes and write-back beat
	reg_bank #(.NUM_REGS(NUM_REGS), .BANK_ODD(1'b0)) even_bank (
		.clock    (clock),
		.reset    (reset),
		.rd_idx_a (rd_idx_a),
		.rd_idx_b (rd_idx_b),
		.rd_data_a(even_a),
		.rd_data_b(even_b),
		.wb       (retire)
	);

	reg_bank #(.NUM_REGS(NUM_REGS), .BANK_ODD(1'b1)) odd_bank (
		.clock    (clock),
		.reset    (reset),
		.rd_idx_a (rd_idx_a),
		.rd_idx_b (rd_idx_b),
		.rd_data_a(odd_a),
		.rd_data_b(odd_b),
		.wb       (retire)
	);

	exec_unit i_exec_unit (
		.clock(clock),
		.reset(reset),
		.issue(issue),
		.wb   (retire),
		.halt (halt),
		.term (term)
	);

endmodule

//--- verif/tb_scalar_core.sv
//////////////////////////////////////////////////
// Testbench for the scalar pipeline
//  clock, reset and APB host transfers
//  reference model of registers and retire beats
//  assertions on retire, term and status
//////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_scalar_core import scalar_pkg::*; ();
	localparam int TIMEOUT = 2000;

	logic     clock;
	logic     reset;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	wb_t      retire;
	logic     term;

	// Reference model state
	data_t    model_regs [16];
	instr_t   prog [$];
	wb_t      exp_q [$];
	wb_t      exp_head;
	int       exp_count;
	int       term_count;
	int       seed;
	opcode_t  op;

	scalar_core #(.IMEM_DEPTH(64), .NUM_REGS(16)) i_scalar_core (
		.clock  (clock),
		.reset  (reset),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.retire (retire),
		.term   (term)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic update_head();
		exp_count = exp_q.size();
		exp_head  = (exp_count > 0) ? exp_q[0] : '0;
	endtask

	//////////////////////////////////////////////////
	// Retire and term checks
	assert property (@(negedge clock) disable iff (reset) retire.valid |-> exp_count > 0)
	else begin
		$display("error at %0t: retire beat arrived with no beat left to expect", $time);
		abort_run();
	end

	assert property (@(negedge clock) disable iff (reset)
		retire.valid && exp_count > 0 |->
		retire.dst == exp_head.dst && retire.data == exp_head.data)
	else begin
		$display("error at %0t: retire expected dst %0d data %h, actual dst %0d data %h",
			$time, exp_head.dst, exp_head.data, retire.dst, retire.data);
		abort_run();
	end

	assert property (@(negedge clock) disable iff (reset) term |=> !term)
	else begin
		$display("error at %0t: term stayed high for more than one cycle", $time);
		abort_run();
	end

	// Retire head moves on each beat
	always @(posedge clock) begin
		if (!reset && retire.valid && exp_q.size() > 0) begin
			void'(exp_q.pop_front());
			update_head();
		end
	end

	always @(posedge clock) begin
		if (!reset && term)
			term_count++;
	end

	task automatic apb_transfer(input logic write, input logic [11:0] addr, input data_t wdata,
			output data_t rdata, output logic err);
		int n;
		@(posedge clock);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
		@(posedge clock);
		apb_req.penable <= 1'b1;
		n = 0;
		@(negedge clock);
		while (!apb_rsp.pready) begin
			n++;
			if (n > TIMEOUT) begin
				$display("timeout at %0t: pready never came in the access phase", $time);
				abort_run();
			end
			@(negedge clock);
		end
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		@(posedge clock);
		apb_req <= '0;
	endtask

	task automatic check_status(input logic running, input logic halted, input int count);
		data_t rd;
		data_t exp;
		logic  err;
		apb_transfer(1'b0, STATUS_ADDR, '0, rd, err);
		exp = {16'h0, 8'(count), 6'h0, halted, running};
		assert (!err && rd == exp)
		else begin
			$display("error at %0t: status prdata expected %h, actual %h", $time, exp, rd);
			abort_run();
		end
	endtask

	// Append one instruction and run it through the model
	task automatic add_op(input opcode_t opc, input int dst, input int s1, input int s2,
			input int imm);
		data_t a;
		data_t b;
		data_t res;
		prog.push_back('{opcode: opc, dst: 4'(dst), src1: 4'(s1), src2: 4'(s2), imm: 16'(imm)});
		a = model_regs[4'(s1)];
		b = model_regs[4'(s2)];
		case (opc)
			LDI:     res = {16'h0, 16'(imm)};
			ADD:     res = a + b;
			SUB:     res = a - b;
			AND:     res = a & b;
			OR:      res = a | b;
			XOR:     res = a ^ b;
			SHL:     res = a << b[4:0];
			default: res = '0;
		endcase
		if (opc != HALT && opc != NOP) begin
			model_regs[4'(dst)] = res;
			exp_q.push_back('{valid: 1'b1, dst: 4'(dst), data: res});
		end
		update_head();
	endtask

	//////////////////////////////////////////////////
	// Load, start, probe the host port, wait for HALT
	task automatic run_program(input bit probe);
		data_t rd;
		logic  err;
		int    beats;
		int    n;
		beats = exp_q.size();
		term_count = 0;
		for (int i = 0; i < prog.size(); i++) begin
			apb_transfer(1'b1, IMEM_BASE + 12'(4 * i), data_t'(prog[i]), rd, err);
			assert (!err)
			else begin
				$display("error at %0t: pslverr expected 0, actual 1 on a program load", $time);
				abort_run();
			end
		end
		apb_transfer(1'b1, CTRL_ADDR, 32'h1, rd, err);
		if (probe) begin
			// Aim at a slot the pipeline has not fetched yet
			apb_transfer(1'b1, IMEM_BASE + 12'(4 * (prog.size() - 2)), 32'hffff_ffff, rd, err);
			assert (err)
			else begin
				$display("error at %0t: pslverr expected 1, actual 0 on a write while running",
					$time);
				abort_run();
			end
			apb_transfer(1'b0, 12'h200, '0, rd, err);
			assert (err)
			else begin
				$display("error at %0t: pslverr expected 1, actual 0 on an unmapped read", $time);
				abort_run();
			end
		end
		n = 0;
		while (term_count == 0) begin
			@(negedge clock);
			n++;
			if (n > TIMEOUT) begin
				$display("timeout at %0t: no term pulse after the program started", $time);
				abort_run();
			end
		end
		n = 0;
		while (exp_count > 0) begin
			@(negedge clock);
			n++;
			if (n > TIMEOUT) begin
				$display("timeout at %0t: %0d retire beats never arrived", $time, exp_count);
				abort_run();
			end
		end
		check_status(1'b0, 1'b1, beats);
		assert (term_count == 1)
		else begin
			$display("error at %0t: term_count expected 1, actual %0d", $time, term_count);
			abort_run();
		end
	endtask

	initial begin
		seed = 40081;
		reset = 1'b1;
		apb_req = '0;
		term_count = 0;
		for (int r = 0; r < 16; r++)
			model_regs[r] = '0;
		update_head();
		repeat (4) @(posedge clock);
		reset <= 1'b0;

		// Idle state after reset
		check_status(1'b0, 1'b0, 0);
		@(negedge clock);
		assert (!retire.valid && !term)
		else begin
			$display("error at %0t: retire.valid expected 0, actual %b, term expected 0, actual %b",
				$time, retire.valid, term);
			abort_run();
		end

		// Every ALU op, both banks
		add_op(LDI, 1, 0, 0, 'h1234);
		add_op(LDI, 2, 0, 0, 'h0ff0);
		add_op(LDI, 3, 0, 0, 4);
		add_op(LDI, 4, 0, 0, 'h8001);
		add_op(ADD, 5, 1, 2, 0);
		add_op(SUB, 6, 2, 1, 0);
		add_op(AND, 7, 4, 2, 0);
		add_op(OR, 8, 1, 4, 0);
		add_op(XOR, 9, 2, 4, 0);
		add_op(SHL, 10, 1, 3, 0);
		add_op(HALT, 0, 0, 0, 0);
		run_program(1'b0);

		// Dependent chain, host port probed while it runs
		prog.delete();
		add_op(LDI, 1, 0, 0, 3);
		for (int i = 0; i < 12; i++)
			add_op(opcode_t'(4'(2 + i % 6)), 2 + i, 1 + i, (i % 2 == 1) ? 1 : 1 + i, 0);
		add_op(HALT, 0, 0, 0, 0);
		run_program(1'b1);

		// Random program
		prog.delete();
		for (int i = 0; i < 40; i++) begin
			op = opcode_t'(4'(1 + $unsigned($random(seed)) % 7));
			add_op(op, $random(seed) & 15, $random(seed) & 15, $random(seed) & 15,
				$random(seed) & 'hffff);
		end
		add_op(HALT, 0, 0, 0, 0);
		run_program(1'b0);

		$display("PASS: all tests");
		$finish;
	end

endmodule

//--- vlog.f
design/scalar_pkg.sv
design/host_apb_if.sv
design/fetch_unit.sv
design/reg_bank.sv
design/issue_unit.sv
design/exec_unit.sv
design/scalar_core.sv
verif/tb_scalar_core.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --assert --timing -Wno-fatal -j 0
TOP      = tb_scalar_core
RTL_TOP  = scalar_core
FILELIST = vlog.f
LOG      = sim.log
PASS_MSG = PASS: all tests
FAIL_MSG = FAIL: see errors above

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

lint:
	$(SIM) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
